// File: run_sim.sh
#!/bin/sh
# build the cache with its testbench, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module icache_tb \
    -Mdir obj_dir -o icache_sim -f src.f \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: source/cache_maintenance.sv
`timescale 1ns/1ns
`default_nettype none

module cache_maintenance (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                cacop_valid_i,
    input  wire  [1:0]         cacop_op_i,
    input  wire  [31:0]        cacop_addr_i,
    tag_write_if.writer        tag_wr,
    output logic               cacop_done_o
);
    import icache_pkg::*;

    logic               busy_q;
    logic               done_q;
    way_mask_t          mask_q;
    logic [INDEX_W-1:0] index_q;
    way_mask_t          op_mask;
    logic               accept;

    // op 0/1 pick one way by addr bit 0, op 2 both, op 3 none
    always_comb begin
        case (cacop_op_i)
            2'd0, 2'd1: op_mask = cacop_addr_i[0] ? way_mask_t'(2'b10) : way_mask_t'(2'b01);
            2'd2:       op_mask = '1;
            default:    op_mask = '0;
        endcase
    end

    assign accept = cacop_valid_i && !busy_q && !done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (accept) begin
            busy_q <= |op_mask;
            done_q <= ~|op_mask;
        end else if (busy_q && tag_wr.gnt) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
        end else begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mask_q  <= op_mask;
            index_q <= cacop_addr_i[11:5];
        end
    end

    // invalidate writes an all-zero entry
    assign tag_wr.req   = busy_q;
    assign tag_wr.index = index_q;
    assign tag_wr.ways  = mask_q;
    assign tag_wr.entry = '0;

    assign cacop_done_o = done_q;

endmodule

`default_nettype wire

// File: source/dual_port_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
    parameter type         DATA_T = logic [31:0],
    parameter int unsigned DEPTH  = 128
) (
    input  wire                       clk,
    input  wire  [$clog2(DEPTH)-1:0]  waddr_i,
    input  wire                       wen_i,
    input  wire  DATA_T               wdata_i,
    input  wire  [$clog2(DEPTH)-1:0]  raddr_i,
    output DATA_T                     rdata_o
);

    DATA_T mem [DEPTH];

    // read before write on a colliding address
    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry, two ways of 4 KiB
    localparam int unsigned WAY_NUM      = 2;
    localparam int unsigned SET_NUM      = 128;
    localparam int unsigned LINE_WORDS   = 8;
    localparam int unsigned PAIR_NUM     = SET_NUM * LINE_WORDS / 2;

    // address split: tag 31:12, set 11:5, pair 4:3
    localparam int unsigned INDEX_W      = $clog2(SET_NUM);
    localparam int unsigned PAIR_IDX_W   = $clog2(PAIR_NUM);
    localparam int unsigned TAG_W        = 32 - 12;

    // bus length of an uncached fetch
    localparam int unsigned UNCACHED_LEN = 2;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

    // element 0 holds the lower address
    typedef logic [1:0][31:0] inst_pair_t;

    typedef logic [WAY_NUM-1:0] way_mask_t;

endpackage

`default_nettype wire

// File: source/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     fetch_valid_i,
    input  wire  [31:0]             fetch_pc_i,
    input  wire                     fetch_uncached_i,
    output logic                    fetch_ready_o,
    output logic                    inst_valid_o,
    output logic [31:0]             inst_pc_o,
    output icache_pkg::inst_pair_t  inst_data_o,
    input  wire                     inst_ready_i,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o,
    output logic [7:0]              mem_len_o,
    input  wire                     mem_ack_i,
    input  wire                     mem_rvalid_i,
    input  wire  [31:0]             mem_rdata_i,
    input  wire                     cacop_valid_i,
    input  wire  [1:0]              cacop_op_i,
    input  wire  [31:0]             cacop_addr_i,
    output logic                    cacop_done_o
);
    import icache_pkg::*;

    logic                  lk_valid;
    logic [31:0]           lk_pc;
    logic                  lk_unc;
    logic                  out_valid;
    logic [31:0]           out_pc;
    inst_pair_t            out_data;
    way_mask_t             hit;
    inst_pair_t            lk_pair;
    logic                  out_free;
    logic                  lk_miss;
    logic                  lk_fire;
    logic                  fetch_fire;
    logic                  refill_start;
    logic                  refill_busy;
    logic                  refill_done;
    inst_pair_t            refill_pair;
    way_mask_t             data_wen;
    logic [PAIR_IDX_W-1:0] data_widx;
    inst_pair_t            data_wdata;
    logic [31:0]           rd_pc;

    tag_write_if refill_tw ();
    tag_write_if maint_tw ();
    tag_write_if lookup_tw ();

    assign out_free     = !out_valid || inst_ready_i;
    assign lk_miss      = lk_unc || (hit == '0);
    assign lk_fire      = lk_valid && !lk_miss && out_free;
    assign fetch_ready_o = (!lk_valid || lk_fire) && out_free;
    assign fetch_fire   = fetch_valid_i && fetch_ready_o;
    // output stage must be free so the refill result always has a slot
    assign refill_start = lk_valid && lk_miss && !refill_busy && out_free;
    // re-read the stalled PC so the lookup result stays current
    assign rd_pc        = fetch_fire ? fetch_pc_i : lk_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (fetch_fire) begin
                lk_valid <= 1'b1;
            end else if (lk_fire || refill_done) begin
                lk_valid <= 1'b0;
            end
            if (lk_fire || refill_done) begin
                out_valid <= 1'b1;
            end else if (inst_ready_i) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            lk_pc  <= fetch_pc_i;
            lk_unc <= fetch_uncached_i;
        end
        if (lk_fire || refill_done) begin
            out_pc   <= {lk_pc[31:3], 3'b000};
            out_data <= lk_fire ? lk_pair : refill_pair;
        end
    end

    assign inst_valid_o = out_valid;
    assign inst_pc_o    = out_pc;
    assign inst_data_o  = out_data;

    way_lookup u_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_pc_i      (rd_pc),
        .tag_wr       (lookup_tw),
        .data_wen_i   (data_wen),
        .data_widx_i  (data_widx),
        .data_wdata_i (data_wdata),
        .hit_o        (hit),
        .pair_o       (lk_pair)
    );

    refill_engine u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (refill_start),
        .start_pc_i   (lk_pc),
        .uncached_i   (lk_unc),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_len_o    (mem_len_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .tag_wr       (refill_tw),
        .data_wen_o   (data_wen),
        .data_widx_o  (data_widx),
        .data_wdata_o (data_wdata),
        .busy_o       (refill_busy),
        .done_o       (refill_done),
        .pair_o       (refill_pair)
    );

    cache_maintenance u_maint (
        .clk           (clk),
        .rst_n         (rst_n),
        .cacop_valid_i (cacop_valid_i),
        .cacop_op_i    (cacop_op_i),
        .cacop_addr_i  (cacop_addr_i),
        .tag_wr        (maint_tw),
        .cacop_done_o  (cacop_done_o)
    );

    tag_write_arbiter u_arb (
        .refill_wr (refill_tw),
        .maint_wr  (maint_tw),
        .tag_port  (lookup_tw)
    );

endmodule

`default_nettype wire

// File: source/refill_engine.sv
`timescale 1ns/1ns
`default_nettype none

module refill_engine (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 start_i,
    input  wire  [31:0]                         start_pc_i,
    input  wire                                 uncached_i,
    output logic                                mem_req_o,
    output logic [31:0]                         mem_addr_o,
    output logic [7:0]                          mem_len_o,
    input  wire                                 mem_ack_i,
    input  wire                                 mem_rvalid_i,
    input  wire  [31:0]                         mem_rdata_i,
    tag_write_if.writer                         tag_wr,
    output icache_pkg::way_mask_t               data_wen_o,
    output logic [icache_pkg::PAIR_IDX_W-1:0]   data_widx_o,
    output icache_pkg::inst_pair_t              data_wdata_o,
    output logic                                busy_o,
    output logic                                done_o,
    output icache_pkg::inst_pair_t              pair_o
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_STREAM,
        S_TAG
    } state_t;

    state_t             state_q;
    logic [31:0]        pc_q;
    logic               unc_q;
    logic [2:0]         word_cnt_q;
    logic [31:0]        low_word_q;
    inst_pair_t         pair_q;
    logic [SET_NUM-1:0] victim_q;
    logic               done_q;
    logic [INDEX_W-1:0] set_idx;
    way_mask_t          victim_mask;
    inst_pair_t         beat_pair;
    logic               pair_beat;
    logic               last_beat;
    logic               want_pair;

    assign set_idx     = pc_q[11:5];
    assign victim_mask = victim_q[set_idx] ? way_mask_t'(2'b10) : way_mask_t'(2'b01);

    // odd beat completes a pair with the buffered even word
    assign beat_pair = {mem_rdata_i, low_word_q};
    assign pair_beat = (state_q == S_STREAM) && mem_rvalid_i && word_cnt_q[0];
    assign last_beat = (state_q == S_STREAM) && mem_rvalid_i
                    && (word_cnt_q == 3'(unc_q ? UNCACHED_LEN - 1 : LINE_WORDS - 1));
    assign want_pair = unc_q || (word_cnt_q[2:1] == pc_q[4:3]);

    assign mem_req_o  = (state_q == S_REQ);
    assign mem_addr_o = unc_q ? {pc_q[31:3], 3'b000} : {pc_q[31:5], 5'b00000};
    assign mem_len_o  = unc_q ? 8'(UNCACHED_LEN) : 8'(LINE_WORDS);

    // uncached bursts never touch the arrays
    assign data_wen_o   = (pair_beat && !unc_q) ? victim_mask : '0;
    assign data_widx_o  = {set_idx, word_cnt_q[2:1]};
    assign data_wdata_o = beat_pair;

    assign tag_wr.req   = (state_q == S_TAG);
    assign tag_wr.index = set_idx;
    assign tag_wr.ways  = victim_mask;
    assign tag_wr.entry = '{tag: pc_q[31:12], valid: 1'b1};

    // still busy in the done cycle so the same miss is not restarted
    assign busy_o = (state_q != S_IDLE) || done_q;
    assign done_o = done_q;
    assign pair_o = pair_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            word_cnt_q <= '0;
            victim_q   <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mem_ack_i) begin
                        state_q    <= S_STREAM;
                        word_cnt_q <= '0;
                    end
                end
                S_STREAM: begin
                    if (mem_rvalid_i) begin
                        word_cnt_q <= word_cnt_q + 3'd1;
                    end
                    if (last_beat && unc_q) begin
                        state_q <= S_IDLE;
                        done_q  <= 1'b1;
                    end else if (last_beat) begin
                        state_q <= S_TAG;
                    end
                end
                S_TAG: begin
                    if (tag_wr.gnt) begin
                        // next miss in this set takes the other way
                        victim_q[set_idx] <= !victim_q[set_idx];
                        state_q           <= S_IDLE;
                        done_q            <= 1'b1;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            pc_q  <= start_pc_i;
            unc_q <= uncached_i;
        end
        if (state_q == S_STREAM && mem_rvalid_i && !word_cnt_q[0]) begin
            low_word_q <= mem_rdata_i;
        end
        // keep the pair the requester asked for
        if (pair_beat && want_pair) begin
            pair_q <= beat_pair;
        end
    end

endmodule

`default_nettype wire

// File: source/tag_write_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tag_write_arbiter (
    tag_write_if.arbiter refill_wr,
    tag_write_if.arbiter maint_wr,
    tag_write_if.writer  tag_port
);

    logic refill_sel;

    // refill always wins
    assign refill_sel = refill_wr.req;

    assign tag_port.req   = refill_wr.req || maint_wr.req;
    assign tag_port.index = refill_sel ? refill_wr.index : maint_wr.index;
    assign tag_port.ways  = refill_sel ? refill_wr.ways : maint_wr.ways;
    assign tag_port.entry = refill_sel ? refill_wr.entry : maint_wr.entry;

    // grant only the winner, and only once the tag port takes it
    assign refill_wr.gnt = refill_sel && tag_port.gnt;
    assign maint_wr.gnt  = !refill_sel && maint_wr.req && tag_port.gnt;

endmodule

`default_nettype wire

// File: source/tag_write_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tag_write_if;
    import icache_pkg::*;

    logic               req;
    logic [INDEX_W-1:0] index;
    way_mask_t          ways;
    tag_entry_t         entry;
    logic               gnt;

    modport writer  (output req, output index, output ways, output entry, input gnt);
    modport arbiter (input req, input index, input ways, input entry, output gnt);
    // req doubles as the write strobe at the tag array
    modport port    (input req, input index, input ways, input entry, output gnt);

endinterface

`default_nettype wire

// File: source/way_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module way_lookup (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [31:0]                         rd_pc_i,
    tag_write_if.port                           tag_wr,
    input  wire  icache_pkg::way_mask_t         data_wen_i,
    input  wire  [icache_pkg::PAIR_IDX_W-1:0]   data_widx_i,
    input  wire  icache_pkg::inst_pair_t        data_wdata_i,
    output icache_pkg::way_mask_t               hit_o,
    output icache_pkg::inst_pair_t              pair_o
);
    import icache_pkg::*;

    logic [INDEX_W-1:0]    rd_idx;
    logic [PAIR_IDX_W-1:0] rd_pidx;
    logic [TAG_W-1:0]      rd_tag_q;
    way_mask_t             tag_fwd_q;
    way_mask_t             data_fwd_q;
    tag_entry_t            tag_wdata_q;
    inst_pair_t            data_wdata_q;
    tag_entry_t            tag_rd [WAY_NUM];
    inst_pair_t            data_rd [WAY_NUM];
    tag_entry_t            tag_res [WAY_NUM];
    inst_pair_t            data_res [WAY_NUM];

    assign rd_idx  = rd_pc_i[11:5];
    assign rd_pidx = rd_pc_i[11:3];

    // tag array takes every write it is offered
    assign tag_wr.gnt = tag_wr.req;

    // remember same-cycle write collisions per way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_fwd_q  <= '0;
            data_fwd_q <= '0;
        end else begin
            tag_fwd_q  <= (tag_wr.req && tag_wr.index == rd_idx) ? tag_wr.ways : '0;
            data_fwd_q <= (data_widx_i == rd_pidx) ? data_wen_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q     <= rd_pc_i[31:12];
        tag_wdata_q  <= tag_wr.entry;
        data_wdata_q <= data_wdata_i;
    end

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        dual_port_ram #(.DATA_T(tag_entry_t), .DEPTH(SET_NUM)) u_tag_ram (
            .clk     (clk),
            .waddr_i (tag_wr.index),
            .wen_i   (tag_wr.req && tag_wr.ways[w]),
            .wdata_i (tag_wr.entry),
            .raddr_i (rd_idx),
            .rdata_o (tag_rd[w])
        );

        dual_port_ram #(.DATA_T(inst_pair_t), .DEPTH(PAIR_NUM)) u_data_ram (
            .clk     (clk),
            .waddr_i (data_widx_i),
            .wen_i   (data_wen_i[w]),
            .wdata_i (data_wdata_i),
            .raddr_i (rd_pidx),
            .rdata_o (data_rd[w])
        );

        assign tag_res[w]  = tag_fwd_q[w] ? tag_wdata_q : tag_rd[w];
        assign data_res[w] = data_fwd_q[w] ? data_wdata_q : data_rd[w];
        assign hit_o[w]    = tag_res[w].valid && (tag_res[w].tag == rd_tag_q);
    end

    always_comb begin
        pair_o = data_res[0];
        for (int w = 0; w < WAY_NUM; w++) begin
            if (hit_o[w]) begin
                pair_o = data_res[w];
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
source/icache_pkg.sv
source/tag_write_if.sv
source/dual_port_ram.sv
source/tag_write_arbiter.sv
source/way_lookup.sv
source/refill_engine.sv
source/cache_maintenance.sv
source/icache_top.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam logic [31:0] SEED    = 32'h4a47_df5e;
    // memory content rule: word at A is A xor this key
    localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;

    typedef enum logic [1:0] {K_FETCH, K_BURST, K_CACOP} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [31:0] addr;
        logic        unc;
        logic [1:0]  op;
        logic [7:0]  exp_len;
        inst_pair_t  exp_pair;
    } row_t;

    logic        clk              = 1'b0;
    logic        rst_n            = 1'b0;
    logic        fetch_valid_i    = 1'b0;
    logic [31:0] fetch_pc_i       = '0;
    logic        fetch_uncached_i = 1'b0;
    logic        inst_ready_i     = 1'b1;
    logic        mem_ack_i        = 1'b0;
    logic        mem_rvalid_i     = 1'b0;
    logic [31:0] mem_rdata_i      = '0;
    logic        cacop_valid_i    = 1'b0;
    logic [1:0]  cacop_op_i       = '0;
    logic [31:0] cacop_addr_i     = '0;
    logic        fetch_ready_o;
    logic        inst_valid_o;
    logic [31:0] inst_pc_o;
    inst_pair_t  inst_data_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic [7:0]  mem_len_o;
    logic        cacop_done_o;

    row_t        rows[$];
    logic [31:0] res_pc_q[$];
    inst_pair_t  res_data_q[$];
    int          res_cyc_q[$];
    logic [31:0] bus_addr_q[$];
    logic [7:0]  bus_len_q[$];
    int          cycle_cnt      = 0;
    int          timeout_cycles = 1000;
    int          check_cnt      = 0;
    int          error_cnt      = 0;
    int          done_count     = 0;
    int          cacop_issued   = 0;
    logic        hold_ready     = 1'b0;
    logic        held_valid     = 1'b0;
    logic [31:0] held_pc;
    inst_pair_t  held_data;

    // memory model state
    logic [1:0]  m_state = 2'd0;
    logic [31:0] m_addr;
    logic [7:0]  m_len;
    logic [7:0]  m_cnt;
    logic [2:0]  m_delay;
    logic [31:0] mem_rng = SEED;
    logic [31:0] rdy_rng = SEED;

    always #2 clk = ~clk;

    icache_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_uncached_i (fetch_uncached_i),
        .fetch_ready_o    (fetch_ready_o),
        .inst_valid_o     (inst_valid_o),
        .inst_pc_o        (inst_pc_o),
        .inst_data_o      (inst_data_o),
        .inst_ready_i     (inst_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_ack_i        (mem_ack_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_op_i       (cacop_op_i),
        .cacop_addr_i     (cacop_addr_i),
        .cacop_done_o     (cacop_done_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ MEM_KEY;
    endfunction

    function automatic inst_pair_t expected_pair(input logic [31:0] pc);
        logic [31:0] base;
        base = {pc[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    task automatic verify(input logic ok, input string what);
        check_cnt++;
        assert (ok) else begin
            error_cnt++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Run stopped: the tests did not finish within %0d cycles", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // random drops of inst_ready_i, about one cycle in four
    always @(posedge clk) begin
        rdy_rng = xorshift32(rdy_rng);
        if (!hold_ready && rdy_rng[9:8] == 2'b00) begin
            inst_ready_i <= 1'b0;
        end else begin
            inst_ready_i <= 1'b1;
        end
    end

    // memory: random ack delay, then the burst with random gaps
    always @(posedge clk) begin
        mem_rng = xorshift32(mem_rng);
        mem_ack_i    <= 1'b0;
        mem_rvalid_i <= 1'b0;
        if (!rst_n) begin
            m_state <= 2'd0;
        end else begin
            case (m_state)
                2'd0: begin
                    if (mem_req_o) begin
                        bus_addr_q.push_back(mem_addr_o);
                        bus_len_q.push_back(mem_len_o);
                        m_addr  <= mem_addr_o;
                        m_len   <= mem_len_o;
                        m_delay <= mem_rng[2:0];
                        m_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (m_delay == 3'd0) begin
                        mem_ack_i <= 1'b1;
                        m_cnt     <= 8'd0;
                        m_state   <= 2'd2;
                    end else begin
                        m_delay <= m_delay - 3'd1;
                    end
                end
                default: begin
                    if (mem_rng[4:3] != 2'b00) begin
                        mem_rvalid_i <= 1'b1;
                        mem_rdata_i  <= mem_word(m_addr + {22'd0, m_cnt, 2'b00});
                        m_cnt        <= m_cnt + 8'd1;
                        if (m_cnt == m_len - 8'd1) begin
                            m_state <= 2'd0;
                        end
                    end
                end
            endcase
        end
    end

    // output monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (held_valid) begin
                verify(inst_valid_o === 1'b1, "inst_valid_o dropped while stalled");
                verify(inst_pc_o === held_pc && inst_data_o === held_data,
                       $sformatf("output changed while stalled, pc %h", inst_pc_o));
            end
            if (inst_valid_o && !inst_ready_i) begin
                verify(fetch_ready_o === 1'b0, "fetch_ready_o high while output stalled");
            end
            held_valid = inst_valid_o && !inst_ready_i;
            held_pc    = inst_pc_o;
            held_data  = inst_data_o;
            if (inst_valid_o && inst_ready_i) begin
                res_pc_q.push_back(inst_pc_o);
                res_data_q.push_back(inst_data_o);
                res_cyc_q.push_back(cycle_cnt);
            end
            if (cacop_done_o) begin
                done_count++;
            end
        end
    end

    task automatic add_row(input kind_t kind, input logic [31:0] addr, input logic unc,
                           input logic [1:0] op, input logic [7:0] exp_len);
        row_t row;
        row.kind     = kind;
        row.addr     = addr;
        row.unc      = unc;
        row.op       = op;
        row.exp_len  = exp_len;
        row.exp_pair = '0;
        if (kind != K_CACOP) begin
            row.exp_pair = expected_pair(addr);
        end
        rows.push_back(row);
    endtask

    // called at a rising edge, returns at the edge that accepts the fetch
    task automatic issue_fetch(input logic [31:0] pc, input logic unc);
        fetch_valid_i    <= 1'b1;
        fetch_pc_i       <= pc;
        fetch_uncached_i <= unc;
        do begin
            @(negedge clk);
        end while (fetch_ready_o !== 1'b1);
        @(posedge clk);
    endtask

    task automatic wait_results(input int n);
        while (res_pc_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic check_result(input logic [31:0] pc, input inst_pair_t exp_pair,
                                output int cyc);
        logic [31:0] got_pc;
        inst_pair_t  got_data;
        got_pc   = res_pc_q.pop_front();
        got_data = res_data_q.pop_front();
        cyc      = res_cyc_q.pop_front();
        verify(got_pc === {pc[31:3], 3'b000},
               $sformatf("inst_pc_o %h, expected %h", got_pc, {pc[31:3], 3'b000}));
        verify(got_data === exp_pair,
               $sformatf("pair %h for pc %h, expected %h", got_data, pc, exp_pair));
    endtask

    task automatic check_bus(input logic [7:0] exp_len, input logic [31:0] pc);
        logic [31:0] exp_addr;
        exp_addr = (exp_len == 8'd8) ? {pc[31:5], 5'b00000} : {pc[31:3], 3'b000};
        if (exp_len == 8'd0) begin
            verify(bus_len_q.size() == 0, $sformatf("unexpected bus request for pc %h", pc));
        end else begin
            verify(bus_len_q.size() == 1,
                   $sformatf("%0d bus requests for pc %h, expected 1", bus_len_q.size(), pc));
            if (bus_len_q.size() > 0) begin
                verify(bus_len_q[0] == exp_len,
                       $sformatf("bus length %0d, expected %0d", bus_len_q[0], exp_len));
                verify(bus_addr_q[0] == exp_addr,
                       $sformatf("bus address %h, expected %h", bus_addr_q[0], exp_addr));
            end
        end
        bus_len_q.delete();
        bus_addr_q.delete();
    endtask

    task automatic run_fetch(input row_t row);
        int cyc;
        issue_fetch(row.addr, row.unc);
        fetch_valid_i <= 1'b0;
        wait_results(1);
        check_result(row.addr, row.exp_pair, cyc);
        check_bus(row.exp_len, row.addr);
    endtask

    // four hits on one line, back to back with inst_ready_i held high
    task automatic run_burst(input row_t row);
        int cyc[4];
        hold_ready <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 4; i++) begin
            issue_fetch(row.addr + 32'(8 * i), 1'b0);
        end
        fetch_valid_i <= 1'b0;
        wait_results(4);
        for (int i = 0; i < 4; i++) begin
            check_result(row.addr + 32'(8 * i), expected_pair(row.addr + 32'(8 * i)), cyc[i]);
            if (i > 0) begin
                verify(cyc[i] == cyc[i-1] + 1, "hit burst not one result per cycle");
            end
        end
        check_bus(8'd0, row.addr);
        hold_ready <= 1'b0;
    endtask

    task automatic do_cacop(input logic [1:0] op, input logic [31:0] addr);
        cacop_valid_i <= 1'b1;
        cacop_op_i    <= op;
        cacop_addr_i  <= addr;
        do begin
            @(negedge clk);
        end while (cacop_done_o !== 1'b1);
        @(posedge clk);
        cacop_valid_i <= 1'b0;
        @(posedge clk);
        cacop_issued++;
        verify(done_count == cacop_issued,
               $sformatf("%0d cacop_done_o pulses, expected %0d", done_count, cacop_issued));
    endtask

    initial begin
        // lines: D 0x100 (set 8), U 0x500 (set 40), A/B/C share set 2
        add_row(K_FETCH, 32'h0000_0108, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_0100, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_011c, 1'b0, 2'd0, 8'd0);
        add_row(K_BURST, 32'h0000_0100, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_0504, 1'b1, 2'd0, 8'd2);
        add_row(K_FETCH, 32'h0000_0504, 1'b1, 2'd0, 8'd2);
        add_row(K_FETCH, 32'h0000_0110, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_050c, 1'b1, 2'd0, 8'd2);
        add_row(K_FETCH, 32'h0000_0508, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_0108, 1'b1, 2'd0, 8'd2);
        add_row(K_FETCH, 32'h0000_0108, 1'b0, 2'd0, 8'd0);
        // replacement, victim toggles way 0, 1, 0, 1
        add_row(K_FETCH, 32'h0000_1040, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_2048, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_3050, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_2040, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_3040, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_1058, 1'b0, 2'd0, 8'd8);
        // now way 0 holds C, way 1 holds A
        add_row(K_CACOP, 32'h0000_0040, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_1040, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_3040, 1'b0, 2'd0, 8'd8);
        add_row(K_CACOP, 32'h0000_0041, 1'b0, 2'd1, 8'd0);
        add_row(K_FETCH, 32'h0000_3048, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_1040, 1'b0, 2'd0, 8'd8);
        add_row(K_CACOP, 32'h0000_0040, 1'b0, 2'd2, 8'd0);
        add_row(K_FETCH, 32'h0000_3040, 1'b0, 2'd0, 8'd8);
        add_row(K_FETCH, 32'h0000_1040, 1'b0, 2'd0, 8'd8);
        add_row(K_CACOP, 32'h0000_0040, 1'b0, 2'd3, 8'd0);
        add_row(K_FETCH, 32'h0000_3058, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_1048, 1'b0, 2'd0, 8'd0);
        add_row(K_FETCH, 32'h0000_0100, 1'b0, 2'd0, 8'd0);
        timeout_cycles = (rows.size() + int'(SET_NUM)) * 60 + 200;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // tag valid bits start unknown, clear every set
        for (int s = 0; s < int'(SET_NUM); s++) begin
            do_cacop(2'd2, 32'(s) << 5);
        end

        foreach (rows[r]) begin
            verify(res_pc_q.size() == 0, "stray result before next request");
            case (rows[r].kind)
                K_FETCH: run_fetch(rows[r]);
                K_BURST: run_burst(rows[r]);
                default: do_cacop(rows[r].op, rows[r].addr);
            endcase
        end

        repeat (4) @(posedge clk);
        verify(res_pc_q.size() == 0, "extra result after the last request");
        verify(bus_len_q.size() == 0, "extra bus request after the last request");
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
